// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - common/bypass_if.sv
  - hw/reg_file.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/rv_core.sv
  - target: simulation
    files:
      - dv/tb_rv_core.sv

// ==== common/bypass_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Results of the memory and writeback stages, fed back to execute
interface bypass_if;

  rv_pkg::reg_idx_t m_rd;
  rv_pkg::word_t    m_rd_data;
  logic             m_we;

  rv_pkg::reg_idx_t w_rd;
  rv_pkg::word_t    w_rd_data;
  logic             w_we;

  modport src (
    output m_rd, m_rd_data, m_we,
    output w_rd, w_rd_data, w_we
  );

  modport sink (
    input m_rd, m_rd_data, m_we,
    input w_rd, w_rd_data, w_we
  );

endinterface

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  localparam word_t pc_reset = 32'h0000_0000;
  localparam word_t pc_step = 32'd4;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // INSN_NONE marks bubbles and anything the decoder does not recognize
  typedef enum logic [5:0] {
    INSN_NONE,
    INSN_LUI,
    INSN_ADDI, INSN_SLTI, INSN_SLTIU, INSN_XORI, INSN_ORI, INSN_ANDI,
    INSN_SLLI, INSN_SRLI, INSN_SRAI,
    INSN_ADD, INSN_SUB, INSN_SLL, INSN_SLT, INSN_SLTU,
    INSN_XOR, INSN_SRL, INSN_SRA, INSN_OR, INSN_AND,
    INSN_BEQ, INSN_BNE, INSN_BLT, INSN_BGE, INSN_BLTU, INSN_BGEU,
    INSN_LW, INSN_LB,
    INSN_ECALL
  } insn_e;

  // What occupies writeback in a given cycle, one-hot except for INVALID
  typedef enum logic [5:0] {
    CYCLE_INVALID      = 6'd0,
    CYCLE_RESET        = 6'd1,
    CYCLE_NO_STALL     = 6'd2,
    CYCLE_TAKEN_BRANCH = 6'd4,
    CYCLE_LOAD2USE     = 6'd8
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_state_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    insn_e         insn_name;
    word_t         imm_i;
    word_t         imm_b;
    word_t         imm_u;
  } execute_state_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    insn_e         insn_name;
    reg_idx_t      rd;
    word_t         rd_data;
    // Word-aligned load address plus the byte offset within the word
    word_t         addr;
    logic [1:0]    addr_lo;
    logic          we;
    logic          halt;
  } memory_state_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    word_t         rd_data;
    logic          we;
    logic          halt;
  } writeback_state_t;

endpackage

`default_nettype wire

// ==== dv/rv_trace.txt ====
# mem word_address data
# cyc status pc insn we rd rd_data  (status 1 reset, 2 no stall, 4 taken branch, 8 load-use)
mem 00 800000B7  lui   x1, 0x80000
mem 01 FFB00113  addi  x2, x0, -5
mem 02 00C10193  addi  x3, x2, 12
mem 03 FFC12213  slti  x4, x2, -4
mem 04 00513293  sltiu x5, x2, 5
mem 05 0F01C313  xori  x6, x3, 0xf0
mem 06 F0036393  ori   x7, x6, -256
mem 07 7FF3F413  andi  x8, x7, 0x7ff
mem 08 00419493  slli  x9, x3, 4
mem 09 0040D513  srli  x10, x1, 4
mem 0A 4040D593  srai  x11, x1, 4
mem 0B 00918633  add   x12, x3, x9
mem 0C 409186B3  sub   x13, x3, x9
mem 0D 00919733  sll   x14, x3, x9
mem 0E 003127B3  slt   x15, x2, x3
mem 0F 00313833  sltu  x16, x2, x3
mem 10 008348B3  xor   x17, x6, x8
mem 11 0030D933  srl   x18, x1, x3
mem 12 4030D9B3  sra   x19, x1, x3
mem 13 01166A33  or    x20, x12, x17
mem 14 0086FAB3  and   x21, x13, x8
mem 15 00118013  addi  x0, x3, 1
mem 16 00300B33  add   x22, x0, x3
mem 17 01618463  beq   x3, x22, +8   taken
mem 18 00100B93  addi  x23, x0, 1    skipped
mem 19 01619463  bne   x3, x22, +8   not taken
mem 1A 00314463  blt   x2, x3, +8    taken
mem 1B 00200B93  addi  x23, x0, 2    skipped
mem 1C 00315463  bge   x2, x3, +8    not taken
mem 1D 00316463  bltu  x2, x3, +8    not taken
mem 1E 00317463  bgeu  x2, x3, +8    taken
mem 1F 00300B93  addi  x23, x0, 3    skipped
mem 20 10000C13  addi  x24, x0, 0x100
mem 21 004C2C83  lw    x25, 4(x24)
mem 22 003C8D33  add   x26, x25, x3
mem 23 000C0D83  lb    x27, 0(x24)
mem 24 001C0E03  lb    x28, 1(x24)
mem 25 000D8E93  addi  x29, x27, 0
mem 26 002C0F03  lb    x30, 2(x24)
mem 27 003C0F83  lb    x31, 3(x24)
mem 28 00000073  ecall
mem 40 807F01FE  data at 0x100
mem 41 12345678  data at 0x104
cyc 1 00 00000000 0 00 00000000
cyc 1 00 00000000 0 00 00000000
cyc 1 00 00000000 0 00 00000000
cyc 2 00 800000B7 1 01 80000000
cyc 2 04 FFB00113 1 02 FFFFFFFB
cyc 2 08 00C10193 1 03 00000007
cyc 2 0C FFC12213 1 04 00000001
cyc 2 10 00513293 1 05 00000000
cyc 2 14 0F01C313 1 06 000000F7
cyc 2 18 F0036393 1 07 FFFFFFF7
cyc 2 1C 7FF3F413 1 08 000007F7
cyc 2 20 00419493 1 09 00000070
cyc 2 24 0040D513 1 0A 08000000
cyc 2 28 4040D593 1 0B F8000000
cyc 2 2C 00918633 1 0C 00000077
cyc 2 30 409186B3 1 0D FFFFFF97
cyc 2 34 00919733 1 0E 00070000
cyc 2 38 003127B3 1 0F 00000001
cyc 2 3C 00313833 1 10 00000000
cyc 2 40 008348B3 1 11 00000700
cyc 2 44 0030D933 1 12 01000000
cyc 2 48 4030D9B3 1 13 FF000000
cyc 2 4C 01166A33 1 14 00000777
cyc 2 50 0086FAB3 1 15 00000797
cyc 2 54 00118013 1 00 00000008
cyc 2 58 00300B33 1 16 00000007
cyc 2 5C 01618463 0 08 00000000
cyc 4 00 00000000 0 00 00000000
cyc 4 00 00000000 0 00 00000000
cyc 2 64 01619463 0 08 00000000
cyc 2 68 00314463 0 08 00000000
cyc 4 00 00000000 0 00 00000000
cyc 4 00 00000000 0 00 00000000
cyc 2 70 00315463 0 08 00000000
cyc 2 74 00316463 0 08 00000000
cyc 2 78 00317463 0 08 00000000
cyc 4 00 00000000 0 00 00000000
cyc 4 00 00000000 0 00 00000000
cyc 2 80 10000C13 1 18 00000100
cyc 2 84 004C2C83 1 19 12345678
cyc 8 00 00000000 0 00 00000000
cyc 2 88 003C8D33 1 1A 1234567F
cyc 2 8C 000C0D83 1 1B FFFFFFFE
cyc 2 90 001C0E03 1 1C 00000001
cyc 2 94 000D8E93 1 1D FFFFFFFE
cyc 2 98 002C0F03 1 1E 0000007F
cyc 2 9C 003C0F83 1 1F FFFFFF80
cyc 2 A0 00000073 0 00 00000000

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

  // One expected writeback cycle as listed in the trace file
  typedef struct packed {
    logic [5:0]  status;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
  } cycle_entry_t;

  localparam int mem_words = 256;
  localparam int halt_timeout = 2000;
  localparam logic [31:0] ecall_insn = 32'h0000_0073;

  logic                  clk;
  logic                  rst;
  rv_pkg::word_t         pc_to_imem;
  rv_pkg::word_t         insn_from_imem;
  rv_pkg::word_t         addr_to_dmem;
  rv_pkg::word_t         load_data_from_dmem;
  logic                  halt;
  rv_pkg::word_t         trace_writeback_pc;
  rv_pkg::word_t         trace_writeback_insn;
  rv_pkg::cycle_status_e trace_writeback_cycle_status;
  rv_pkg::reg_idx_t      trace_writeback_rd;
  rv_pkg::word_t         trace_writeback_rd_data;
  logic                  trace_writeback_we;

  rv_pkg::word_t mem [mem_words];
  cycle_entry_t  expected_cycles [$];
  int            value_errors;
  int            other_errors;

  rv_core u_dut (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .insn_from_imem               (insn_from_imem),
    .addr_to_dmem                 (addr_to_dmem),
    .load_data_from_dmem          (load_data_from_dmem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_rd_data      (trace_writeback_rd_data),
    .trace_writeback_we           (trace_writeback_we)
  );

  always #4 clk = ~clk;

  // Instruction and data ports share one word-indexed array
  always @(negedge clk) begin
    insn_from_imem <= mem[pc_to_imem[9:2]];
    load_data_from_dmem <= mem[addr_to_dmem[9:2]];
  end

  task automatic load_trace();
    int               fd;
    int               code;
    bit               done;
    logic [8*4-1:0]   tag;
    logic [8*128-1:0] rest;
    logic [31:0]      addr;
    logic [31:0]      data;
    logic [31:0]      f_status;
    logic [31:0]      f_pc;
    logic [31:0]      f_insn;
    logic [31:0]      f_we;
    logic [31:0]      f_rd;
    logic [31:0]      f_rd_data;
    fd = $fopen("dv/rv_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file dv/rv_trace.txt");
      other_errors++;
      return;
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        done = 1'b1;
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "mem") begin
        code = $fscanf(fd, "%h %h", addr, data);
        if (code != 2) begin
          $display("A mem line in the trace file is malformed");
          other_errors++;
          done = 1'b1;
        end else begin
          mem[addr[7:0]] = data;
        end
        code = $fgets(rest, fd);
      end else if (tag == "cyc") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", f_status, f_pc, f_insn, f_we, f_rd,
                       f_rd_data);
        if (code != 6) begin
          $display("A cyc line in the trace file is malformed");
          other_errors++;
          done = 1'b1;
        end else begin
          expected_cycles.push_back({f_status[5:0], f_pc, f_insn, f_we[0], f_rd[4:0],
                                     f_rd_data});
        end
        code = $fgets(rest, fd);
      end else begin
        $display("The trace file holds a line of unknown type");
        other_errors++;
        done = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_field(input string name, input logic [31:0] expected_value,
                               input logic [31:0] actual_value);
    assert (actual_value === expected_value) else begin
      $display("error: %s expected 0x%h actual 0x%h at %0t", name, expected_value,
               actual_value, $time);
      value_errors++;
    end
  endtask

  task automatic check_cycle(input cycle_entry_t entry);
    compare_field("trace_writeback_cycle_status", {26'b0, entry.status},
                  {26'b0, trace_writeback_cycle_status});
    compare_field("trace_writeback_pc", entry.pc, trace_writeback_pc);
    compare_field("trace_writeback_insn", entry.insn, trace_writeback_insn);
    compare_field("trace_writeback_we", {31'b0, entry.we}, {31'b0, trace_writeback_we});
    compare_field("trace_writeback_rd", {27'b0, entry.rd}, {27'b0, trace_writeback_rd});
    compare_field("trace_writeback_rd_data", entry.rd_data, trace_writeback_rd_data);
    // Halt follows ECALL in writeback
    compare_field("halt", {31'b0, entry.insn == ecall_insn}, {31'b0, halt});
  endtask

  initial begin
    int cycle;
    int index;
    bit done;
    clk = 1'b0;
    rst = 1'b1;
    insn_from_imem = '0;
    load_data_from_dmem = '0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
    load_trace();
    repeat (2) @(negedge clk);
    rst = 1'b0;

    cycle = 0;
    index = 0;
    done = 1'b0;
    while (!done && cycle < halt_timeout) begin
      @(negedge clk);
      cycle++;
      if (index < expected_cycles.size()) begin
        check_cycle(expected_cycles[index]);
        index++;
        done = halt;
      end else begin
        $display("The trace ran out before halt rose");
        other_errors++;
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("Timed out after %0d cycles waiting for halt", halt_timeout);
      other_errors++;
    end else if (index < expected_cycles.size()) begin
      $display("Halt rose with %0d trace cycles left", expected_cycles.size() - index);
      other_errors++;
    end

    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  wire                    clk,
  input  wire                    rst,
  input  rv_pkg::decode_state_t  decode_state,
  input  logic                   branch_taken,
  output logic                   load_stall,
  output rv_pkg::execute_state_t execute_state
);

  rv_pkg::opcode_e  d_opcode;
  logic [2:0]       d_funct3;
  logic [6:0]       d_funct7;
  rv_pkg::reg_idx_t d_rs1;
  rv_pkg::reg_idx_t d_rs2;
  rv_pkg::reg_idx_t d_rd;
  rv_pkg::word_t    d_imm_i;
  rv_pkg::word_t    d_imm_b;
  rv_pkg::word_t    d_imm_u;
  rv_pkg::insn_e    d_insn_name;

  assign d_opcode = rv_pkg::opcode_e'(decode_state.insn[6:0]);
  assign d_funct3 = decode_state.insn[14:12];
  assign d_funct7 = decode_state.insn[31:25];
  assign d_rs1    = decode_state.insn[19:15];
  assign d_rs2    = decode_state.insn[24:20];
  assign d_rd     = decode_state.insn[11:7];

  assign d_imm_i = {{20{decode_state.insn[31]}}, decode_state.insn[31:20]};
  assign d_imm_b = {{19{decode_state.insn[31]}}, decode_state.insn[31], decode_state.insn[7],
                    decode_state.insn[30:25], decode_state.insn[11:8], 1'b0};
  assign d_imm_u = {decode_state.insn[31:12], 12'b0};

  always_comb begin
    d_insn_name = rv_pkg::INSN_NONE;
    case (d_opcode)
      rv_pkg::OPC_LUI: d_insn_name = rv_pkg::INSN_LUI;
      rv_pkg::OPC_LOAD: begin
        if (d_funct3 == 3'b010) begin
          d_insn_name = rv_pkg::INSN_LW;
        end else if (d_funct3 == 3'b000) begin
          d_insn_name = rv_pkg::INSN_LB;
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        case ({d_funct7, d_funct3})
          10'b0000000_001: d_insn_name = rv_pkg::INSN_SLLI;
          10'b0000000_101: d_insn_name = rv_pkg::INSN_SRLI;
          10'b0100000_101: d_insn_name = rv_pkg::INSN_SRAI;
          default: begin
            // The remaining funct3 values carry immediate bits in funct7
            case (d_funct3)
              3'b000:  d_insn_name = rv_pkg::INSN_ADDI;
              3'b010:  d_insn_name = rv_pkg::INSN_SLTI;
              3'b011:  d_insn_name = rv_pkg::INSN_SLTIU;
              3'b100:  d_insn_name = rv_pkg::INSN_XORI;
              3'b110:  d_insn_name = rv_pkg::INSN_ORI;
              3'b111:  d_insn_name = rv_pkg::INSN_ANDI;
              default: d_insn_name = rv_pkg::INSN_NONE;
            endcase
          end
        endcase
      end
      rv_pkg::OPC_OP: begin
        case ({d_funct7, d_funct3})
          10'b0000000_000: d_insn_name = rv_pkg::INSN_ADD;
          10'b0100000_000: d_insn_name = rv_pkg::INSN_SUB;
          10'b0000000_001: d_insn_name = rv_pkg::INSN_SLL;
          10'b0000000_010: d_insn_name = rv_pkg::INSN_SLT;
          10'b0000000_011: d_insn_name = rv_pkg::INSN_SLTU;
          10'b0000000_100: d_insn_name = rv_pkg::INSN_XOR;
          10'b0000000_101: d_insn_name = rv_pkg::INSN_SRL;
          10'b0100000_101: d_insn_name = rv_pkg::INSN_SRA;
          10'b0000000_110: d_insn_name = rv_pkg::INSN_OR;
          10'b0000000_111: d_insn_name = rv_pkg::INSN_AND;
          default:         d_insn_name = rv_pkg::INSN_NONE;
        endcase
      end
      rv_pkg::OPC_BRANCH: begin
        case (d_funct3)
          3'b000:  d_insn_name = rv_pkg::INSN_BEQ;
          3'b001:  d_insn_name = rv_pkg::INSN_BNE;
          3'b100:  d_insn_name = rv_pkg::INSN_BLT;
          3'b101:  d_insn_name = rv_pkg::INSN_BGE;
          3'b110:  d_insn_name = rv_pkg::INSN_BLTU;
          3'b111:  d_insn_name = rv_pkg::INSN_BGEU;
          default: d_insn_name = rv_pkg::INSN_NONE;
        endcase
      end
      rv_pkg::OPC_SYSTEM: begin
        if (decode_state.insn[31:7] == '0) begin
          d_insn_name = rv_pkg::INSN_ECALL;
        end
      end
      default: d_insn_name = rv_pkg::INSN_NONE;
    endcase
  end

  // A load in execute whose result is needed by the instruction in decode
  assign load_stall = (execute_state.insn_name inside {rv_pkg::INSN_LW, rv_pkg::INSN_LB}) &&
                      (execute_state.rd != '0) &&
                      (execute_state.rd == d_rs1 || execute_state.rd == d_rs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{status: rv_pkg::CYCLE_RESET, insn_name: rv_pkg::INSN_NONE,
                         default: '0};
    end else if (branch_taken) begin
      execute_state <= '{status: rv_pkg::CYCLE_TAKEN_BRANCH, insn_name: rv_pkg::INSN_NONE,
                         default: '0};
    end else if (load_stall) begin
      execute_state <= '{status: rv_pkg::CYCLE_LOAD2USE, insn_name: rv_pkg::INSN_NONE,
                         default: '0};
    end else begin
      execute_state <= '{
        pc:        decode_state.pc,
        insn:      decode_state.insn,
        status:    decode_state.status,
        rs1:       d_rs1,
        rs2:       d_rs2,
        rd:        d_rd,
        insn_name: d_insn_name,
        imm_i:     d_imm_i,
        imm_b:     d_imm_b,
        imm_u:     d_imm_u
      };
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  wire                    clk,
  input  wire                    rst,
  input  rv_pkg::execute_state_t execute_state,
  bypass_if.sink                 bypass,
  output logic                   branch_taken,
  output rv_pkg::word_t          branch_target,
  output rv_pkg::memory_state_t  memory_state
);

  rv_pkg::word_t rf_rs1_data;
  rv_pkg::word_t rf_rs2_data;
  rv_pkg::word_t rs1_val;
  rv_pkg::word_t rs2_val;
  rv_pkg::word_t op_b;
  rv_pkg::word_t x_sum;
  rv_pkg::word_t x_result;
  logic          x_we;
  logic          x_cond;
  logic          x_halt;

  // Writeback drives the write port, execute reads
  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (execute_state.rs1),
    .rs2      (execute_state.rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .rd       (bypass.w_rd),
    .rd_data  (bypass.w_rd_data),
    .we       (bypass.w_we)
  );

  // Newest value wins, so the memory stage is checked last
  function automatic rv_pkg::word_t bypass_operand(rv_pkg::reg_idx_t rs,
                                                   rv_pkg::word_t rf_data);
    rv_pkg::word_t value;
    value = rf_data;
    if (rs != '0 && bypass.w_we && bypass.w_rd == rs) begin
      value = bypass.w_rd_data;
    end
    if (rs != '0 && bypass.m_we && bypass.m_rd == rs) begin
      value = bypass.m_rd_data;
    end
    return value;
  endfunction

  always_comb begin
    rs1_val = bypass_operand(execute_state.rs1, rf_rs1_data);
    rs2_val = bypass_operand(execute_state.rs2, rf_rs2_data);
  end

  // Opcode bit 5 separates OP and BRANCH from OP_IMM and LOAD
  assign op_b = execute_state.insn[5] ? rs2_val : execute_state.imm_i;

  // One adder for ADD, ADDI and the load address
  assign x_sum = rs1_val + op_b;

  // Branch funct3 bits 14:13 pick the compare, bit 12 inverts it
  always_comb begin
    case (execute_state.insn[14:13])
      2'b10:   x_cond = $signed(rs1_val) < $signed(rs2_val);
      2'b11:   x_cond = rs1_val < rs2_val;
      default: x_cond = rs1_val == rs2_val;
    endcase
  end

  always_comb begin
    x_result = '0;
    x_we = 1'b1;
    branch_taken = 1'b0;
    case (execute_state.insn_name)
      rv_pkg::INSN_LUI:                    x_result = execute_state.imm_u;
      rv_pkg::INSN_ADDI, rv_pkg::INSN_ADD: x_result = x_sum;
      rv_pkg::INSN_SUB:                    x_result = rs1_val - rs2_val;
      rv_pkg::INSN_SLTI, rv_pkg::INSN_SLT: begin
        x_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
      end
      rv_pkg::INSN_SLTIU, rv_pkg::INSN_SLTU: x_result = {31'b0, rs1_val < op_b};
      rv_pkg::INSN_XORI, rv_pkg::INSN_XOR:   x_result = rs1_val ^ op_b;
      rv_pkg::INSN_ORI, rv_pkg::INSN_OR:     x_result = rs1_val | op_b;
      rv_pkg::INSN_ANDI, rv_pkg::INSN_AND:   x_result = rs1_val & op_b;
      rv_pkg::INSN_SLLI, rv_pkg::INSN_SLL:   x_result = rs1_val << op_b[4:0];
      rv_pkg::INSN_SRLI, rv_pkg::INSN_SRL:   x_result = rs1_val >> op_b[4:0];
      rv_pkg::INSN_SRAI, rv_pkg::INSN_SRA: begin
        x_result = $signed(rs1_val) >>> op_b[4:0];
      end
      // Load data replaces this in the memory stage
      rv_pkg::INSN_LW, rv_pkg::INSN_LB:      x_result = x_sum;
      rv_pkg::INSN_BEQ, rv_pkg::INSN_BNE, rv_pkg::INSN_BLT,
      rv_pkg::INSN_BGE, rv_pkg::INSN_BLTU, rv_pkg::INSN_BGEU: begin
        x_we = 1'b0;
        branch_taken = x_cond ^ execute_state.insn[12];
      end
      default: x_we = 1'b0;
    endcase
  end

  assign branch_target = execute_state.pc + execute_state.imm_b;
  assign x_halt = execute_state.insn_name == rv_pkg::INSN_ECALL;

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{status: rv_pkg::CYCLE_RESET, insn_name: rv_pkg::INSN_NONE,
                        default: '0};
    end else begin
      memory_state <= '{
        pc:        execute_state.pc,
        insn:      execute_state.insn,
        status:    execute_state.status,
        insn_name: execute_state.insn_name,
        rd:        execute_state.rd,
        rd_data:   x_result,
        addr:      {x_sum[31:2], 2'b00},
        addr_lo:   x_sum[1:0],
        we:        x_we,
        halt:      x_halt
      };
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  wire                   clk,
  input  wire                   rst,
  input  logic                  branch_taken,
  input  rv_pkg::word_t         branch_target,
  input  logic                  load_stall,
  input  rv_pkg::word_t         insn_from_imem,
  output rv_pkg::word_t         pc_to_imem,
  output rv_pkg::decode_state_t decode_state
);

  rv_pkg::word_t pc;

  assign pc_to_imem = pc;

  // Redirect wins over the load-use hold
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::pc_reset;
      decode_state <= '{status: rv_pkg::CYCLE_RESET, default: '0};
    end else if (branch_taken) begin
      pc <= branch_target;
      decode_state <= '{status: rv_pkg::CYCLE_TAKEN_BRANCH, default: '0};
    end else if (!load_stall) begin
      pc <= pc + rv_pkg::pc_step;
      decode_state <= '{pc: pc, insn: insn_from_imem, status: rv_pkg::CYCLE_NO_STALL};
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
  input  wire                      clk,
  input  wire                      rst,
  input  rv_pkg::memory_state_t    memory_state,
  input  rv_pkg::word_t            load_data_from_dmem,
  output rv_pkg::word_t            addr_to_dmem,
  bypass_if.src                    bypass,
  output rv_pkg::writeback_state_t writeback_state
);

  logic [7:0]    m_byte;
  rv_pkg::word_t m_rd_data;

  assign addr_to_dmem = memory_state.addr;

  // Byte lane chosen by the low address bits
  assign m_byte = load_data_from_dmem[{memory_state.addr_lo, 3'b000} +: 8];

  always_comb begin
    case (memory_state.insn_name)
      rv_pkg::INSN_LW: m_rd_data = load_data_from_dmem;
      rv_pkg::INSN_LB: m_rd_data = {{24{m_byte[7]}}, m_byte};
      default:         m_rd_data = memory_state.rd_data;
    endcase
  end

  // MX source sees load data in the same cycle it arrives
  assign bypass.m_rd      = memory_state.rd;
  assign bypass.m_rd_data = m_rd_data;
  assign bypass.m_we      = memory_state.we;

  assign bypass.w_rd      = writeback_state.rd;
  assign bypass.w_rd_data = writeback_state.rd_data;
  assign bypass.w_we      = writeback_state.we;

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_state <= '{status: rv_pkg::CYCLE_RESET, default: '0};
    end else begin
      writeback_state <= '{
        pc:      memory_state.pc,
        insn:    memory_state.insn,
        status:  memory_state.status,
        rd:      memory_state.rd,
        rd_data: m_rd_data,
        we:      memory_state.we,
        halt:    memory_state.halt
      };
    end
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  logic             we
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::word_t         pc_to_imem,
  input  rv_pkg::word_t         insn_from_imem,
  output rv_pkg::word_t         addr_to_dmem,
  input  rv_pkg::word_t         load_data_from_dmem,
  output logic                  halt,
  output rv_pkg::word_t         trace_writeback_pc,
  output rv_pkg::word_t         trace_writeback_insn,
  output rv_pkg::cycle_status_e trace_writeback_cycle_status,
  output rv_pkg::reg_idx_t      trace_writeback_rd,
  output rv_pkg::word_t         trace_writeback_rd_data,
  output logic                  trace_writeback_we
);

  rv_pkg::decode_state_t    decode_state;
  rv_pkg::execute_state_t   execute_state;
  rv_pkg::memory_state_t    memory_state;
  rv_pkg::writeback_state_t writeback_state;
  logic                     branch_taken;
  rv_pkg::word_t            branch_target;
  logic                     load_stall;

  bypass_if u_bypass ();

  fetch_stage u_fetch (
    .clk            (clk),
    .rst            (rst),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .load_stall     (load_stall),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .decode_state   (decode_state)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .decode_state  (decode_state),
    .branch_taken  (branch_taken),
    .load_stall    (load_stall),
    .execute_state (execute_state)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .bypass        (u_bypass.sink),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .memory_state  (memory_state)
  );

  memory_stage u_memory (
    .clk                 (clk),
    .rst                 (rst),
    .memory_state        (memory_state),
    .load_data_from_dmem (load_data_from_dmem),
    .addr_to_dmem        (addr_to_dmem),
    .bypass              (u_bypass.src),
    .writeback_state     (writeback_state)
  );

  assign halt                         = writeback_state.halt;
  assign trace_writeback_pc           = writeback_state.pc;
  assign trace_writeback_insn         = writeback_state.insn;
  assign trace_writeback_cycle_status = writeback_state.status;
  assign trace_writeback_rd           = writeback_state.rd;
  assign trace_writeback_rd_data      = writeback_state.rd_data;
  assign trace_writeback_we           = writeback_state.we;

endmodule

`default_nettype wire

// ==== src.f ====
common/rv_pkg.sv
common/bypass_if.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core.sv
dv/tb_rv_core.sv
